// File: clock_report_top.f
+incdir+include
src/clock_report_pkg.sv
src/time_unit_counter.sv
src/report_formatter.sv
src/tx_queue.sv
src/clock_report_top.sv
tb/clock_report_assert.sv
tb/clock_report_checker.sv
tb/clock_report_tb.sv

// File: include/clock_report_defs.svh
// clock report constants for counter moduli, line characters and tx queue sizing
`ifndef CLOCK_REPORT_DEFS_SVH
`define CLOCK_REPORT_DEFS_SVH

// ------------------------------------------------------------
// time of day counters
// ------------------------------------------------------------
`define SEC_MOD       60      // seconds wrap
`define MIN_MOD       60      // minutes wrap
`define HR_MOD        24      // hours wrap
`define UNIT_COUNT    3       // sec, min, hr stages

// ------------------------------------------------------------
// report line, CR hh:mm:ss
// ------------------------------------------------------------
`define ASCII_CR      8'h0D
`define ASCII_COLON   8'h3A
`define ASCII_ZERO    8'h30   // digit char is zero plus value
`define LINE_LEN      9

`define TXQ_DEPTH     16
`define TXQ_ADDR_W    4
`define TX_STROBE_LEN 2       // o_rdy cycles per char

`endif

// File: run.sh
#!/bin/sh
# build the clock report testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module clock_report_tb \
	-f clock_report_top.f -o clock_report_sim
./obj_dir/clock_report_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed"
	exit 1
fi

// File: src/clock_report_pkg.sv
// clock report types shared by the counters, the formatter and the tx queue
`default_nettype none

package clock_report_pkg;

	// two decimal digits of one counter
	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] ones;
	} digit_pair_t;

	// hour in the top byte, seconds in the bottom
	typedef struct packed {
		digit_pair_t hr;
		digit_pair_t min;
		digit_pair_t sec;
	} time_of_day_t;

	// one state per character of the line, plus idle
	typedef enum logic [3:0] {
		FMT_IDLE, FMT_CR, FMT_HR_T, FMT_HR_O, FMT_COL1,
		FMT_MIN_T, FMT_MIN_O, FMT_COL2, FMT_SEC_T, FMT_SEC_O
	} fmt_state_t;

	typedef enum logic [1:0] {
		TX_IDLE, TX_STROBE, TX_WAIT_ACCEPT
	} tx_state_t;

endpackage

`default_nettype wire

// File: src/clock_report_top.sv
// clock report top: time of day counters, line formatter and UART tx queue
`default_nettype none
`include "clock_report_defs.svh"

module clock_report_top
	import clock_report_pkg::*;
(
	input  wire        i_sec_in,
	input  wire        i_rst,
	input  wire        i_sec_tick,   // one cycle per second
	input  wire        i_buf_rdy,
	output logic [7:0] o_data,
	output logic       o_rdy
);

	logic [`UNIT_COUNT-1:0] carry_in;
	digit_pair_t            digits [`UNIT_COUNT];
	time_of_day_t           tod;
	logic                   q_write;
	logic                   q_full;
	logic [7:0]             q_char;

	assign carry_in[0] = i_sec_tick;

	// ------------------------------------------------------------
	// sec, min, hr stages, each carrying into the next
	// ------------------------------------------------------------
	for (genvar k = 0; k < `UNIT_COUNT; k++) begin : g_unit
		localparam int MOD = (k == 0) ? `SEC_MOD : ((k == 1) ? `MIN_MOD : `HR_MOD);
		if (k < `UNIT_COUNT - 1) begin : g_mid
			time_unit_counter #(.MODULUS(MOD)) u_counter (
				.i_sec_in(i_sec_in), .i_rst(i_rst), .i_carry_in(carry_in[k]),
				.o_carry_out(carry_in[k + 1]), .o_digits(digits[k])
			);
		end else begin : g_last
			time_unit_counter #(.MODULUS(MOD)) u_counter (
				.i_sec_in(i_sec_in), .i_rst(i_rst), .i_carry_in(carry_in[k]),
				.o_carry_out(), .o_digits(digits[k])   // day wrap goes nowhere
			);
		end
	end

	assign tod.hr  = digits[2];
	assign tod.min = digits[1];
	assign tod.sec = digits[0];

	report_formatter u_formatter (
		.i_sec_in(i_sec_in), .i_rst(i_rst), .i_sec_tick(i_sec_tick), .i_time(tod),
		.i_q_full(q_full), .o_q_write(q_write), .o_q_char(q_char)
	);

	tx_queue u_queue (
		.i_sec_in(i_sec_in), .i_rst(i_rst), .i_write(q_write), .i_char(q_char),
		.o_full(q_full), .i_buf_rdy(i_buf_rdy), .o_data(o_data), .o_rdy(o_rdy)
	);

endmodule

`default_nettype wire

// File: src/report_formatter.sv
// report formatter: writes one CR hh:mm:ss line into the tx queue per reported second
`default_nettype none
`include "clock_report_defs.svh"

module report_formatter
	import clock_report_pkg::*;
(
	input  wire          i_sec_in,
	input  wire          i_rst,
	input  wire          i_sec_tick,
	input  time_of_day_t i_time,
	input  wire          i_q_full,
	output logic         o_q_write,
	output logic [7:0]   o_q_char
);

	fmt_state_t   state;
	fmt_state_t   nxt_state;
	time_of_day_t time_q;    // snapshot taken with the CR
	logic [7:0]   char_c;

	function automatic logic [7:0] digit_char(input logic [3:0] d);
		return `ASCII_ZERO + {4'h0, d};
	endfunction

	// ------------------------------------------------------------
	// character and successor per step
	// ------------------------------------------------------------
	always_comb begin
		nxt_state = state;
		char_c    = `ASCII_CR;
		case (state)
			FMT_CR:    nxt_state = FMT_HR_T;
			FMT_HR_T:  begin char_c = digit_char(time_q.hr.tens);  nxt_state = FMT_HR_O;  end
			FMT_HR_O:  begin char_c = digit_char(time_q.hr.ones);  nxt_state = FMT_COL1;  end
			FMT_COL1:  begin char_c = `ASCII_COLON;                nxt_state = FMT_MIN_T; end
			FMT_MIN_T: begin char_c = digit_char(time_q.min.tens); nxt_state = FMT_MIN_O; end
			FMT_MIN_O: begin char_c = digit_char(time_q.min.ones); nxt_state = FMT_COL2;  end
			FMT_COL2:  begin char_c = `ASCII_COLON;                nxt_state = FMT_SEC_T; end
			FMT_SEC_T: begin char_c = digit_char(time_q.sec.tens); nxt_state = FMT_SEC_O; end
			FMT_SEC_O: begin char_c = digit_char(time_q.sec.ones); nxt_state = FMT_IDLE;  end
			default:   nxt_state = FMT_IDLE;
		endcase
	end

	always_ff @(posedge i_sec_in or posedge i_rst) begin
		if (i_rst) begin
			state <= FMT_IDLE;
		end else if (state == FMT_IDLE) begin
			if (i_sec_tick)
				state <= FMT_CR;   // ticks during a line are not reported
		end else if (!i_q_full) begin
			state <= nxt_state;
		end
	end

	// counters already hold the tick by the time the CR goes out
	always_ff @(posedge i_sec_in) begin
		if (state == FMT_CR && !i_q_full)
			time_q <= i_time;
	end

	assign o_q_write = (state != FMT_IDLE) && !i_q_full;  // stall on full
	assign o_q_char  = char_c;

endmodule

`default_nettype wire

// File: src/time_unit_counter.sv
// time unit counter: one wrapping stage of the clock with carry out and decimal split
`default_nettype none

module time_unit_counter
	import clock_report_pkg::*;
#(
	parameter int MODULUS = 60
) (
	input  wire         i_sec_in,
	input  wire         i_rst,
	input  wire         i_carry_in,   // one cycle strobe from the stage below
	output logic        o_carry_out,
	output digit_pair_t o_digits
);

	localparam int CW       = $clog2(MODULUS);
	localparam int MAX_TENS = (MODULUS - 1) / 10;

	logic [CW-1:0] count;
	logic          at_top;

	assign at_top      = (count == CW'(MODULUS - 1));
	assign o_carry_out = i_carry_in && at_top;   // same cycle as the wrap

	always_ff @(posedge i_sec_in or posedge i_rst) begin
		if (i_rst) begin
			count <= '0;
		end else if (i_carry_in) begin
			if (at_top)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// binary to two digits
	// ------------------------------------------------------------
	// highest tens bucket the count reaches wins
	always_comb begin
		o_digits.tens = 4'd0;
		o_digits.ones = 4'(count);
		for (int t = 1; t <= MAX_TENS; t++) begin
			if (int'(count) >= t * 10) begin
				o_digits.tens = 4'(t);
				o_digits.ones = 4'(int'(count) - t * 10);
			end
		end
	end

endmodule

`default_nettype wire

// File: src/tx_queue.sv
// tx queue: circular character buffer feeding the UART with a timed ready strobe
`default_nettype none
`include "clock_report_defs.svh"

module tx_queue
	import clock_report_pkg::*;
(
	input  wire        i_sec_in,
	input  wire        i_rst,
	input  wire        i_write,
	input  wire  [7:0] i_char,
	output logic       o_full,
	input  wire        i_buf_rdy,    // UART can take a byte
	output logic [7:0] o_data,
	output logic       o_rdy
);

	localparam int CW = `TXQ_ADDR_W + 1;
	localparam int SW = $clog2(`TX_STROBE_LEN + 1);

	logic [7:0]            mem [`TXQ_DEPTH];
	logic [`TXQ_ADDR_W-1:0] wr_idx;
	logic [`TXQ_ADDR_W-1:0] rd_idx;
	logic [CW-1:0]         count;
	tx_state_t             tx_state;
	logic [SW-1:0]         strb_cnt;
	logic                  seen_low;   // UART dropped ready since the last load
	logic                  wr_en;
	logic                  rd_en;
	logic                  empty;

	assign o_full = (count == CW'(`TXQ_DEPTH));
	assign empty  = (count == '0);
	assign wr_en  = i_write && !o_full;
	assign rd_en  = (tx_state == TX_IDLE) && !empty && i_buf_rdy;

	// ------------------------------------------------------------
	// buffer and indices
	// ------------------------------------------------------------
	always_ff @(posedge i_sec_in) begin
		if (wr_en)
			mem[wr_idx] <= i_char;
	end

	always_ff @(posedge i_sec_in or posedge i_rst) begin
		if (i_rst) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_idx <= wr_idx + 1'b1;   // wraps at depth
			if (rd_en)
				rd_idx <= rd_idx + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ------------------------------------------------------------
	// hand-off to the UART
	// ------------------------------------------------------------
	always_ff @(posedge i_sec_in or posedge i_rst) begin
		if (i_rst) begin
			tx_state <= TX_IDLE;
			strb_cnt <= '0;
			seen_low <= 1'b0;
			o_data   <= 8'h00;
		end else begin
			case (tx_state)
				TX_IDLE: begin
					if (rd_en) begin
						o_data   <= mem[rd_idx];   // held until the next load
						strb_cnt <= '0;
						seen_low <= 1'b0;
						tx_state <= TX_STROBE;
					end
				end
				TX_STROBE: begin
					if (!i_buf_rdy)
						seen_low <= 1'b1;
					if (strb_cnt == SW'(`TX_STROBE_LEN - 1))
						tx_state <= TX_WAIT_ACCEPT;
					else
						strb_cnt <= strb_cnt + 1'b1;
				end
				TX_WAIT_ACCEPT: begin
					if (!i_buf_rdy)
						seen_low <= 1'b1;
					else if (seen_low)
						tx_state <= TX_IDLE;   // low then high again, byte taken
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	assign o_rdy = (tx_state == TX_STROBE);

endmodule

`default_nettype wire

// File: tb/clock_report_assert.sv
// tx queue assertions on the ready strobe length, the write side and the UART accept rule
`default_nettype none
`include "clock_report_defs.svh"

module clock_report_assert
	import clock_report_pkg::*;
(
	input wire       i_sec_in,
	input wire       i_rst,
	input wire       i_write,
	input wire       i_full,
	input wire       i_buf_rdy,
	input wire       i_rdy,
	input tx_state_t i_state
);

	int run_len = 0;    // cycles of the current strobe
	int fail_cnt = 0;   // read by the testbench at the end

	always @(posedge i_sec_in)
		run_len <= i_rdy ? run_len + 1 : 0;

	a_strobe_len: assert property (@(posedge i_sec_in) disable iff (i_rst)
		$fell(i_rdy) |-> run_len == `TX_STROBE_LEN)
		else begin
			fail_cnt++;
			$error("o_rdy strobe did not last %0d cycles", `TX_STROBE_LEN);
		end

	a_no_write_full: assert property (@(posedge i_sec_in) disable iff (i_rst)
		i_write |-> !i_full)
		else begin
			fail_cnt++;
			$error("write while the queue is full");
		end

	// a strobe only starts from idle with the UART ready
	a_start_rule: assert property (@(posedge i_sec_in) disable iff (i_rst)
		$rose(i_rdy) |-> $past(i_buf_rdy) && $past(i_state) == TX_IDLE)
		else begin
			fail_cnt++;
			$error("strobe started while the UART was not ready");
		end

endmodule

bind tx_queue clock_report_assert assert_i (
	.i_sec_in(i_sec_in), .i_rst(i_rst), .i_write(i_write), .i_full(o_full),
	.i_buf_rdy(i_buf_rdy), .i_rdy(o_rdy), .i_state(tx_state)
);

`default_nettype wire

// File: tb/clock_report_checker.sv
// line checker: assembles UART characters into report lines and compares them
`default_nettype none
`include "clock_report_defs.svh"

module clock_report_checker (
	input  wire        i_sec_in,
	input  wire [7:0]  i_data,
	input  wire        i_rdy,
	input  wire [71:0] i_exp_line,   // CR in the top byte
	input  wire        i_exact,      // cleared for burst lines that get a format check only
	input  wire        i_silent,     // no character may arrive
	input  int         i_test_id,
	input  wire        i_test_end,
	input  wire        i_finish,
	output int         o_lines,
	output int         o_errors
);

	logic        rdy_q = 1'b0;
	logic [71:0] line_buf = '0;
	int          idx = 0;          // characters of the line so far
	int          chars = 0;
	int          lines = 0;
	int          errors = 0;
	int          test_lines = 0;
	int          test_errs = 0;

	assign o_lines  = lines;
	assign o_errors = errors;

	function automatic logic is_digit(input logic [7:0] c, input int max);
		return c >= `ASCII_ZERO && c <= `ASCII_ZERO + 8'(max);
	endfunction

	// CR hh:mm:ss with hours below 24
	function automatic logic format_ok(input logic [71:0] l);
		return l[71:64] == `ASCII_CR && l[47:40] == `ASCII_COLON
			&& l[23:16] == `ASCII_COLON && l[63:48] <= 16'h3233
			&& is_digit(l[63:56], 2) && is_digit(l[55:48], 9)
			&& is_digit(l[39:32], 5) && is_digit(l[31:24], 9)
			&& is_digit(l[15:8], 5) && is_digit(l[7:0], 9);
	endfunction

	task automatic flag(input string msg);
		errors++;
		test_errs++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic take_char(input logic [7:0] c);
		chars++;
		if (i_silent)
			flag($sformatf("character %h sent while the UART was held off", c));
		if (c == `ASCII_CR) begin
			if (idx != 0)
				flag($sformatf("line cut short after %0d characters", idx));
			line_buf = {c, 64'h0};
			idx = 1;
		end else if (idx == 0) begin
			flag($sformatf("character %h outside any line", c));
		end else begin
			line_buf[71 - 8 * idx -: 8] = c;
			idx++;
			if (idx == `LINE_LEN) begin
				idx = 0;
				lines++;
				test_lines++;
				if (i_exact && line_buf != i_exp_line)
					flag($sformatf("got %s, expected %s", line_buf[63:0], i_exp_line[63:0]));
				else if (!i_exact && !format_ok(line_buf))
					flag($sformatf("malformed line %s", line_buf[63:0]));
			end
		end
	endtask

	// ------------------------------------------------------------
	// sample at the rising edge of o_rdy
	// ------------------------------------------------------------
	always @(posedge i_sec_in) begin
		if (i_rdy && !rdy_q)
			take_char(i_data);
		if (i_test_end) begin
			$display("test %0d done: %0d lines, %0d errors", i_test_id, test_lines, test_errs);
			test_lines = 0;
			test_errs = 0;
		end
		if (i_finish) begin
			if (idx != 0 || chars != lines * `LINE_LEN)
				flag($sformatf("%0d characters do not fill %0d lines", chars, lines));
			$display("totals: %0d lines, %0d characters, %0d errors", lines, chars, errors);
		end
		rdy_q = i_rdy;
	end

endmodule

`default_nettype wire

// File: tb/clock_report_tb.sv
// clock report testbench: tick stimulus, UART accept model, reference lines and watchdog
`default_nettype none
`include "clock_report_defs.svh"

module clock_report_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DAY_SECS     = 86400;
	localparam int SPACED_TICKS = 70;
	localparam int BURST_TICKS  = DAY_SECS - 3 - SPACED_TICKS;   // leaves 23:59:58
	localparam int TOTAL_TICKS  = 1 + SPACED_TICKS + BURST_TICKS + 3;
	localparam int HOLD_CYCLES  = 200;
	localparam int QUIET_CYCLES = 40;
	localparam int CHAR_CYCLES  = 16;   // worst case strobe, accept delay and reload
	localparam longint WATCHDOG_CYCLES =
		longint'(TOTAL_TICKS) * `LINE_LEN * CHAR_CYCLES + HOLD_CYCLES + 10000;

	logic        sec_in = 1'b0;
	logic        rst;
	logic        sec_tick;
	logic        uart_rdy = 1'b1;
	logic        hold_low;
	wire         buf_rdy = uart_rdy && !hold_low;
	wire  [7:0]  data;
	wire         rdy;
	logic [71:0] exp_line;
	logic        exact;
	logic        silent;
	int          test_id;
	logic        test_end;
	logic        finish_run;
	int          chk_lines;
	int          chk_errors;
	int          model_secs;
	int          low_left = 0;     // cycles the UART stays busy
	logic        rdy_prev = 1'b0;
	logic [31:0] lfsr_state = 32'hc9f7eb8d;

	always #(CLK_PERIOD / 2) sec_in = ~sec_in;

	clock_report_top dut_i (
		.i_sec_in(sec_in), .i_rst(rst), .i_sec_tick(sec_tick), .i_buf_rdy(buf_rdy),
		.o_data(data), .o_rdy(rdy)
	);

	clock_report_checker u_checker (
		.i_sec_in(sec_in), .i_data(data), .i_rdy(rdy), .i_exp_line(exp_line),
		.i_exact(exact), .i_silent(silent), .i_test_id(test_id), .i_test_end(test_end),
		.i_finish(finish_run), .o_lines(chk_lines), .o_errors(chk_errors)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic logic [7:0] ascii_digit(input int d);
		return `ASCII_ZERO + 8'(d);
	endfunction

	// expected CR hh:mm:ss for a second count since reset
	function automatic logic [71:0] ref_line(input int secs);
		int s;
		int hh;
		int mm;
		int ss;
		s = secs % DAY_SECS;
		hh = s / 3600;
		mm = (s / 60) % 60;
		ss = s % 60;
		return {`ASCII_CR, ascii_digit(hh / 10), ascii_digit(hh % 10), `ASCII_COLON,
			ascii_digit(mm / 10), ascii_digit(mm % 10), `ASCII_COLON,
			ascii_digit(ss / 10), ascii_digit(ss % 10)};
	endfunction

	// tick once, hold the UART if asked and wait for the whole line
	task automatic spaced_tick(input int hold);
		int lines_before;
		lines_before = chk_lines;
		exp_line = ref_line(model_secs + 1);
		exact = 1'b1;
		sec_tick = 1'b1;
		@(negedge sec_in);
		sec_tick = 1'b0;
		model_secs++;
		repeat (hold) @(negedge sec_in);
		hold_low = 1'b0;
		silent = 1'b0;
		while (chk_lines == lines_before)
			@(negedge sec_in);
	endtask

	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge sec_in);
			quiet = rdy ? 0 : quiet + 1;
		end
	endtask

	task automatic close_test();
		test_end = 1'b1;
		@(negedge sec_in);
		test_end = 1'b0;
		test_id++;
	endtask

	// ------------------------------------------------------------
	// UART model busy for 1 to 8 cycles after each strobe
	// ------------------------------------------------------------
	always @(negedge sec_in) begin
		if (rdy_prev && !rdy) begin
			low_left <= 1 + rand_bits(3);
			uart_rdy <= 1'b0;
		end else if (low_left > 1) begin
			low_left <= low_left - 1;
		end else if (low_left == 1) begin
			low_left <= 0;
			uart_rdy <= 1'b1;
		end
		rdy_prev <= rdy;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		sec_tick = 1'b0;
		hold_low = 1'b0;
		exp_line = '0;
		exact = 1'b1;
		silent = 1'b0;
		test_id = 1;
		test_end = 1'b0;
		finish_run = 1'b0;
		model_secs = 0;
		repeat (RESET_CYCLES) @(negedge sec_in);
		rst = 1'b0;

		silent = 1'b1;   // nothing may come out without a tick
		repeat (50) @(negedge sec_in);
		spaced_tick(0);
		close_test();

		repeat (SPACED_TICKS) spaced_tick(0);   // rollover and minute carry
		close_test();

		exact = 1'b0;
		sec_tick = 1'b1;
		repeat (BURST_TICKS) @(negedge sec_in);
		sec_tick = 1'b0;
		model_secs += BURST_TICKS;
		wait_quiet();
		spaced_tick(0);   // 23:59:59
		spaced_tick(0);   // hour wrap to 00:00:00
		close_test();

		hold_low = 1'b1;
		silent = 1'b1;
		spaced_tick(HOLD_CYCLES - 1);
		close_test();

		finish_run = 1'b1;
		@(negedge sec_in);
		finish_run = 1'b0;
		@(negedge sec_in);
		if (chk_errors == 0 && dut_i.u_queue.assert_i.fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
